// File: files.f
+incdir+logic
logic/stackCachePkg.sv
logic/stackPointerUnit.sv
logic/stackLineStore.sv
logic/stackLineTransfer.sv
logic/stackCache.sv
verification/stackCacheTb.sv

// File: logic/stackCache.sv
// Stack cache top level joining pointer unit, line store and transfer engine
`default_nettype none

`include "stackCache_defs.svh"

module stackCache (
    input  wire logic                    clk,
    input  wire logic                    rstN,
    // Processor side
    input  wire logic                    cmdValid,
    input  wire stackCachePkg::stackCmdT cmd,
    output logic      [`WORD_BITS-1:0]   topData,
    output logic                         topValid,
    output logic                         stall,
    output logic                         boundFault,
    // Stack control
    input  wire logic [`WORD_BITS-1:0]   upperBound,
    input  wire logic [`WORD_BITS-1:0]   lowerBound,
    input  wire logic                    growsUp,
    input  wire logic [`WORD_BITS-1:0]   newPointer,
    input  wire logic                    swap,
    output logic      [`WORD_BITS-1:0]   stackPointer,
    // Memory side
    output logic                         memReq,
    output stackCachePkg::lineReqT       memReqData,
    input  wire logic                    memAck,
    input  wire logic [`LINE_BITS-1:0]   memLineIn
);

    import stackCachePkg::*;

    logic [`WORD_BITS-1:0] targetAddr;
    logic                  targetOk;
    logic                  opAccept;
    logic                  swapTake;
    logic                  missStart;
    missT                  miss;
    logic                  busy;
    logic                  fillDone;
    logic [`LINE_BITS-1:0] fillLine;

    stackPointerUnit pointer_i (
        .clk, .rstN, .cmd, .opAccept, .upperBound, .lowerBound,
        .growsUp, .newPointer, .swapTake, .stackPointer, .targetAddr, .targetOk
    );

    stackLineStore store_i (
        .clk, .rstN, .cmdValid, .cmd, .targetAddr, .targetOk, .stackPointer,
        .swap, .busy, .fillDone, .fillLine, .opAccept, .swapTake, .stall,
        .boundFault, .topData, .topValid, .missStart, .miss
    );

    stackLineTransfer xfer_i (
        .clk, .rstN, .missStart, .miss, .memAck, .memLineIn,
        .busy, .fillDone, .fillLine, .memReq, .memReqData
    );

endmodule

`default_nettype wire

// File: logic/stackCachePkg.sv
// Stack cache types: operation and transfer enums, command, line request and miss structs
`default_nettype none

`include "stackCache_defs.svh"

package stackCachePkg;

    // Byte offset bits inside one line
    localparam int LINE_OFFSET_BITS = $clog2(`LINE_BITS / 8);

    // Processor operation on the stack register
    typedef enum logic [1:0] {
        opNone,
        opPush,
        opPop,
        opPeek
    } stackOpE;

    // Processor request, 34 bits
    typedef struct packed {
        stackOpE                op;
        logic [`WORD_BITS-1:0]  pushData;
    } stackCmdT;

    // Upper address bits naming one line
    typedef logic [`WORD_BITS-LINE_OFFSET_BITS-1:0] lineAddrT;

    // Memory side request, write or read of a whole line
    typedef struct packed {
        logic                   write;
        lineAddrT               lineAddr;
        logic [`LINE_BITS-1:0]  data;
    } lineReqT;

    // Line store asks the transfer engine for a spill and/or fill
    typedef struct packed {
        logic                   spill;
        lineAddrT               spillAddr;
        lineAddrT               fillAddr;
        logic [`LINE_BITS-1:0]  spillData;
    } missT;

    // Transfer engine states
    typedef enum logic [1:0] {
        xferIdle,
        xferSpill,
        xferFill
    } xferStateE;

endpackage

`default_nettype wire

// File: logic/stackCache_defs.svh
// Word, line and reset pointer macros for the stack cache
`ifndef STACK_CACHE_DEFS_SVH
`define STACK_CACHE_DEFS_SVH

// Data word width in bits
`define WORD_BITS 32

// Words held in one cache line
`define LINE_WORDS 8

// Line width in bits, eight words of 32 bits
`define LINE_BITS 256

// Pointer after reset
// Word aligned, sits at the top of a grows-down stack area
`define STACK_RESET_PTR 32'h0000_1000

`endif

// File: logic/stackLineStore.sv
// Resident stack line with tag, valid and dirty, hit check, word access and miss request
`default_nettype none

`include "stackCache_defs.svh"

module stackLineStore (
    input  wire logic                    clk,
    input  wire logic                    rstN,
    input  wire logic                    cmdValid,
    input  wire stackCachePkg::stackCmdT cmd,
    input  wire logic [`WORD_BITS-1:0]   targetAddr,
    input  wire logic                    targetOk,
    input  wire logic [`WORD_BITS-1:0]   stackPointer,
    input  wire logic                    swap,
    input  wire logic                    busy,
    input  wire logic                    fillDone,
    input  wire logic [`LINE_BITS-1:0]   fillLine,
    output logic                         opAccept,
    output logic                         swapTake,
    output logic                         stall,
    output logic                         boundFault,
    output logic      [`WORD_BITS-1:0]   topData,
    output logic                         topValid,
    output logic                         missStart,
    output stackCachePkg::missT          miss
);

    import stackCachePkg::*;

    localparam int WORD_IDX_BITS = $clog2(`LINE_WORDS);

    logic [`LINE_WORDS-1:0][`WORD_BITS-1:0] lineData;
    lineAddrT                               lineTag;
    logic                                   lineValid;
    logic                                   lineDirty;

    lineAddrT                               targetLine;
    logic [WORD_IDX_BITS-1:0]               targetWord;
    logic                                   opReq;
    logic                                   hit;
    logic                                   missReq;
    logic                                   flushReq;
    logic                                   pushAccept;

    // Split target address into line and word index
    assign targetLine = targetAddr[`WORD_BITS-1:LINE_OFFSET_BITS];
    assign targetWord = targetAddr[LINE_OFFSET_BITS-1:2];

    assign opReq = cmdValid && (cmd.op != opNone);
    assign hit   = lineValid && (lineTag == targetLine);

    // Processor handshake
    assign opAccept   = opReq && targetOk && hit && !busy;
    assign stall      = opReq && targetOk && !hit;
    assign boundFault = opReq && !targetOk;
    assign pushAccept = opAccept && (cmd.op == opPush);

    // Pop and peek read at the pointer, which is also the target
    assign topData  = lineData[stackPointer[LINE_OFFSET_BITS-1:2]];
    assign topValid = opAccept && (cmd.op != opPush);

    // Swap only while no operation is pending and the engine rests
    assign swapTake = swap && !cmdValid && !busy;

    // Miss fetches the target line and flush only writes the dirty line out
    assign missReq   = stall && !busy;
    assign flushReq  = swapTake && lineValid && lineDirty;
    assign missStart = missReq || flushReq;

    // Flush is marked by fill address equal to spill address
    always_comb begin
        miss.spill     = lineValid && lineDirty;
        miss.spillAddr = lineTag;
        miss.fillAddr  = flushReq ? lineTag : targetLine;
        miss.spillData = lineData;
    end

    // Line payload and tag
    always_ff @(posedge clk) begin
        if (fillDone) begin
            lineData <= fillLine;
        end else if (pushAccept) begin
            lineData[targetWord] <= cmd.pushData;
        end
        // Tag follows the line being fetched
        if (missReq) begin
            lineTag <= targetLine;
        end
    end

    // Valid and dirty state
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lineValid <= 1'b0;
            lineDirty <= 1'b0;
        end else if (fillDone) begin
            lineValid <= 1'b1;
            lineDirty <= 1'b0;
        end else if (missStart || swapTake) begin
            lineValid <= 1'b0;
            lineDirty <= 1'b0;
        end else if (pushAccept) begin
            lineDirty <= 1'b1;
        end
    end

    // A resident line never coexists with a line transfer, so no access while a line moves
    acceptNotBusy: assert property (
        @(posedge clk) disable iff (!rstN)
        hit |-> !busy
    );

    // Engine picks up each miss and stays busy, so it takes one miss at a time
    missNotBusy: assert property (
        @(posedge clk) disable iff (!rstN)
        missStart |=> busy
    );

endmodule

`default_nettype wire

// File: logic/stackLineTransfer.sv
// Spill and fill engine driving the memory request/acknowledge pair
`default_nettype none

`include "stackCache_defs.svh"

module stackLineTransfer (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   missStart,
    input  wire stackCachePkg::missT    miss,
    input  wire logic                   memAck,
    input  wire logic [`LINE_BITS-1:0]  memLineIn,
    output logic                        busy,
    output logic                        fillDone,
    output logic      [`LINE_BITS-1:0]  fillLine,
    output logic                        memReq,
    output stackCachePkg::lineReqT      memReqData
);

    import stackCachePkg::*;

    xferStateE  state;
    missT       pending;
    logic       fillSuppress;
    logic       spilling;

    assign busy     = (state != xferIdle);
    assign spilling = (state == xferSpill);

    // Capture the miss when it starts
    always_ff @(posedge clk) begin
        if ((state == xferIdle) && missStart) begin
            pending <= miss;
            // Swap flush carries fill address equal to spill address
            fillSuppress <= miss.spill && (miss.fillAddr == miss.spillAddr);
        end
    end

    // Request is built from the held miss, so it stays put until ack
    always_comb begin
        memReqData.write    = spilling;
        memReqData.lineAddr = spilling ? pending.spillAddr : pending.fillAddr;
        memReqData.data     = spilling ? pending.spillData : '0;
    end

    // Fetched line goes straight to the line store
    assign fillDone = (state == xferFill) && memReq && memAck;
    assign fillLine = memLineIn;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= xferIdle;
            memReq <= 1'b0;
        end else begin
            case (state)
                xferIdle: begin
                    if (missStart) begin
                        state  <= miss.spill ? xferSpill : xferFill;
                        memReq <= 1'b1;
                    end
                end
                xferSpill: begin
                    if (memReq && memAck) begin
                        memReq <= 1'b0;
                        state  <= fillSuppress ? xferIdle : xferFill;
                    end
                end
                xferFill: begin
                    if (memReq && memAck) begin
                        memReq <= 1'b0;
                        state  <= xferIdle;
                    end else if (!memReq) begin
                        // One low cycle after the spill ack, then read
                        memReq <= 1'b1;
                    end
                end
                default: begin
                    state  <= xferIdle;
                    memReq <= 1'b0;
                end
            endcase
        end
    end

    // Request held steady until acknowledged
    reqStable: assert property (
        @(posedge clk) disable iff (!rstN)
        memReq && !memAck |=> memReq && $stable(memReqData)
    );

endmodule

`default_nettype wire

// File: logic/stackPointerUnit.sv
// Stack pointer register with target address, bound check and swap load
`default_nettype none

`include "stackCache_defs.svh"

module stackPointerUnit (
    input  wire logic                    clk,
    input  wire logic                    rstN,
    input  wire stackCachePkg::stackCmdT cmd,
    input  wire logic                    opAccept,
    input  wire logic [`WORD_BITS-1:0]   upperBound,
    input  wire logic [`WORD_BITS-1:0]   lowerBound,
    input  wire logic                    growsUp,
    input  wire logic [`WORD_BITS-1:0]   newPointer,
    input  wire logic                    swapTake,
    output logic      [`WORD_BITS-1:0]   stackPointer,
    output logic      [`WORD_BITS-1:0]   targetAddr,
    output logic                         targetOk
);

    import stackCachePkg::*;

    // One word in bytes
    localparam logic [`WORD_BITS-1:0] WORD_STEP = `WORD_BITS'(4);

    logic [`WORD_BITS-1:0] pushStep;
    logic [`WORD_BITS-1:0] nextPointer;

    // Push moves down by default, up when the stack grows up
    assign pushStep = growsUp ? WORD_STEP : -WORD_STEP;

    // Word touched by the operation and pointer after it
    always_comb begin
        targetAddr  = stackPointer;
        nextPointer = stackPointer;
        case (cmd.op)
            opPush: begin
                targetAddr  = stackPointer + pushStep;
                nextPointer = stackPointer + pushStep;
            end
            // Pop reads at the pointer, then steps back
            opPop: begin
                nextPointer = stackPointer - pushStep;
            end
            default: begin
                nextPointer = stackPointer;
            end
        endcase
    end

    // Resulting pointer must stay inside the inclusive window
    assign targetOk = (nextPointer >= lowerBound) && (nextPointer <= upperBound);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stackPointer <= `STACK_RESET_PTR;
        end else if (swapTake) begin
            stackPointer <= newPointer;
        end else if (opAccept) begin
            stackPointer <= nextPointer;
        end
    end

    // Pointer never leaves word alignment, swaps included
    pointerAligned: assert property (
        @(posedge clk) disable iff (!rstN)
        stackPointer[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build the stack cache testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module stackCacheTb \
    && ./obj_dir/VstackCacheTb > sim.log 2>&1 \
    || echo "Build or simulation stopped with an error" >> sim.log
cat sim.log
if grep -q "Checks failed" sim.log || ! grep -q "All checks passed" sim.log; then
    exit 1
fi
exit 0

// File: verification/stackCacheTb.sv
// Stack cache testbench with clock, reset, memory responder, reference model and checks
`default_nettype none

`include "stackCache_defs.svh"

module stackCacheTb;

    import stackCachePkg::*;

    // Expected outcome of one stack operation
    typedef struct packed {
        logic [`WORD_BITS-1:0] ptr;
        logic [`WORD_BITS-1:0] target;
        logic [`WORD_BITS-1:0] value;
        logic                  fault;
    } refResultT;

    // Four phases of up to 300 ops, misses of about 12 cycles, plus margin
    localparam int CYCLE_LIMIT = 20000;
    localparam logic [31:0] SEED = 32'h711c_ad51;

    logic                  clk = 1'b0;
    logic                  rstN;
    logic                  cmdValid;
    stackCmdT              cmd;
    logic [`WORD_BITS-1:0] topData;
    logic                  topValid;
    logic                  stall;
    logic                  boundFault;
    logic [`WORD_BITS-1:0] upperBound;
    logic [`WORD_BITS-1:0] lowerBound;
    logic                  growsUp;
    logic [`WORD_BITS-1:0] newPointer;
    logic                  swap;
    logic [`WORD_BITS-1:0] stackPointer;
    logic                  memReq;
    lineReqT               memReqData;
    logic                  memAck = 1'b0;
    logic [`LINE_BITS-1:0] memLineIn = '0;

    // Reference model state
    logic [`WORD_BITS-1:0] modelMem [logic [`WORD_BITS-1:0]];
    logic [`WORD_BITS-1:0] modelPtr = `STACK_RESET_PTR;
    refResultT             checkRes;
    lineAddrT              expFillLine = '0;
    int                    doneCount = 0;
    int                    acceptCount = 0;
    int                    faultCount = 0;
    int                    cycleCount = 0;
    logic [31:0]           stimSeed = SEED;

    // Memory responder state
    logic [`LINE_BITS-1:0] memLines [lineAddrT];
    lineAddrT              residentLine = '0;
    int                    writeCount = 0;
    logic [31:0]           ackSeed = ~SEED;
    logic                  ackPending = 1'b0;
    int                    ackDelay = 0;

    stackCache dut_i (
        .clk, .rstN, .cmdValid, .cmd, .topData, .topValid, .stall, .boundFault,
        .upperBound, .lowerBound, .growsUp, .newPointer, .swap, .stackPointer,
        .memReq, .memReqData, .memAck, .memLineIn
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return (s * 32'd1664525) + 32'd1013904223;
    endfunction

    // Contents of never written memory mix every address bit
    function automatic logic [`WORD_BITS-1:0] patternWord(input logic [`WORD_BITS-1:0] addr);
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [`WORD_BITS-1:0] modelWord(input logic [`WORD_BITS-1:0] addr);
        if (modelMem.exists(addr)) begin
            return modelMem[addr];
        end
        return patternWord(addr);
    endfunction

    function automatic logic [`LINE_BITS-1:0] readLine(input lineAddrT addr);
        logic [`LINE_BITS-1:0] line;
        int i;
        if (memLines.exists(addr)) begin
            return memLines[addr];
        end
        for (i = 0; i < `LINE_WORDS; i++) begin
            line[i*`WORD_BITS +: `WORD_BITS] =
                patternWord({addr, {LINE_OFFSET_BITS{1'b0}}} + 32'(i * 4));
        end
        return line;
    endfunction

    // Growing down a push stores below the pointer and a pop reads at it then moves up
    function automatic refResultT refOp(input logic [`WORD_BITS-1:0] ptr, input stackOpE op);
        refResultT res;
        logic [`WORD_BITS-1:0] step;
        step       = growsUp ? 32'd4 : -32'd4;
        res.ptr    = ptr;
        res.target = ptr;
        if (op == opPush) begin
            res.ptr    = ptr + step;
            res.target = ptr + step;
        end else if (op == opPop) begin
            res.ptr = ptr - step;
        end
        res.value = modelWord(res.target);
        // Pointer stays when out of range
        res.fault = (res.ptr < lowerBound) || (res.ptr > upperBound);
        if (res.fault) begin
            res.ptr = ptr;
        end
        return res;
    endfunction

    task automatic stopRun();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic expectEqual(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            stopRun();
        end
    endtask

    // Compare mid-cycle where outputs have settled since the drive after the edge
    always @(negedge clk) begin
        if (rstN) begin
            expectEqual("stackPointer", modelPtr, stackPointer);
            if (cmdValid && (cmd.op != opNone)) begin
                checkRes = refOp(modelPtr, cmd.op);
                expectEqual("boundFault", 32'(checkRes.fault), 32'(boundFault));
                if (checkRes.fault) begin
                    // Dropped by the caller
                    expectEqual("topValid", 32'd0, 32'(topValid));
                    faultCount = faultCount + 1;
                    doneCount  = doneCount + 1;
                end else if (stall) begin
                    expFillLine = checkRes.target[`WORD_BITS-1:LINE_OFFSET_BITS];
                end else begin
                    expectEqual("topValid", 32'(cmd.op != opPush), 32'(topValid));
                    if (cmd.op == opPush) begin
                        modelMem[checkRes.target] = cmd.pushData;
                    end else begin
                        expectEqual("topData", checkRes.value, topData);
                    end
                    modelPtr    = checkRes.ptr;
                    acceptCount = acceptCount + 1;
                    doneCount   = doneCount + 1;
                end
            end else if (swap) begin
                modelPtr = newPointer;
            end
        end
    end

    // Spill must match the model and fill returns memory or pattern
    task automatic serveRequest();
        lineAddrT addr;
        int i;
        addr = memReqData.lineAddr;
        if (memReqData.write) begin
            expectEqual("memReqData.lineAddr", 32'(residentLine), 32'(addr));
            for (i = 0; i < `LINE_WORDS; i++) begin
                expectEqual("memReqData.data",
                    modelWord({addr, {LINE_OFFSET_BITS{1'b0}}} + 32'(i * 4)),
                    memReqData.data[i*`WORD_BITS +: `WORD_BITS]);
            end
            memLines[addr] = memReqData.data;
            writeCount     = writeCount + 1;
        end else begin
            expectEqual("memReqData.lineAddr", 32'(expFillLine), 32'(addr));
            memLineIn    = readLine(addr);
            residentLine = addr;
        end
    endtask

    // Memory responder acks after 1 to 4 cycles with a single cycle pulse
    always @(posedge clk) begin
        #1;
        if (memAck) begin
            memAck = 1'b0;
        end else if (memReq) begin
            if (!ackPending) begin
                ackSeed    = lcgNext(ackSeed);
                ackDelay   = 1 + int'(ackSeed[17:16]);
                ackPending = 1'b1;
            end
            ackDelay = ackDelay - 1;
            if (ackDelay == 0) begin
                ackPending = 1'b0;
                serveRequest();
                memAck = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
            stopRun();
        end
    end

    // Called just after an edge and holds the command through stalls
    task automatic runOp(input stackOpE op, input logic [`WORD_BITS-1:0] data);
        int startCount;
        startCount   = doneCount;
        cmd.op       = op;
        cmd.pushData = data;
        cmdValid     = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (doneCount == startCount);
        cmdValid = 1'b0;
        cmd.op   = opNone;
    endtask

    task automatic randomOps(input int count);
        int n;
        int pick;
        for (n = 0; n < count; n++) begin
            stimSeed = lcgNext(stimSeed);
            pick     = int'(stimSeed[31:16]) % 3;
            if (pick == 0) begin
                stimSeed = lcgNext(stimSeed);
                runOp(opPush, stimSeed);
            end else if (pick == 1) begin
                runOp(opPop, '0);
            end else begin
                runOp(opPeek, '0);
            end
        end
    endtask

    // Deep push runs then matching pops cross lines both ways
    task automatic crossLines(input int rounds);
        int r;
        int k;
        int depth;
        for (r = 0; r < rounds; r++) begin
            stimSeed = lcgNext(stimSeed);
            depth    = 12 + int'(stimSeed[20:16]);
            for (k = 0; k < depth; k++) begin
                stimSeed = lcgNext(stimSeed);
                runOp(opPush, stimSeed);
            end
            for (k = 0; k < depth; k++) begin
                runOp(opPop, '0);
            end
        end
    endtask

    initial begin
        logic [`WORD_BITS-1:0] base;
        int writesBefore;
        rstN       = 1'b0;
        cmdValid   = 1'b0;
        cmd        = '0;
        upperBound = 32'h0000_1040;
        lowerBound = 32'h0000_0E00;
        growsUp    = 1'b0;
        newPointer = '0;
        swap       = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        // Quiet outputs after reset
        @(negedge clk);
        expectEqual("memReq", 32'd0, 32'(memReq));
        expectEqual("stall", 32'd0, 32'(stall));
        expectEqual("boundFault", 32'd0, 32'(boundFault));
        expectEqual("stackPointer", `STACK_RESET_PTR, stackPointer);
        @(posedge clk);
        #1;
        // Random grows-down traffic
        randomOps(300);
        lowerBound = 32'h0000_0800;
        crossLines(5);
        // Tight window around the pointer so both ends fault
        lowerBound = modelPtr - 32'd8;
        upperBound = modelPtr + 32'd4;
        runOp(opPush, 32'hA1A1_0001);
        runOp(opPush, 32'hA1A1_0002);
        runOp(opPush, 32'hA1A1_0003);
        runOp(opPop, '0);
        runOp(opPop, '0);
        runOp(opPop, '0);
        runOp(opPop, '0);
        runOp(opPeek, '0);
        // Reversed direction
        growsUp    = 1'b1;
        lowerBound = modelPtr - 32'h40;
        upperBound = modelPtr + 32'h100;
        randomOps(250);
        crossLines(2);
        // Swap after pushes flushes the dirty line
        growsUp    = 1'b0;
        lowerBound = 32'h0000_0800;
        upperBound = 32'h0000_1FFC;
        base       = modelPtr;
        repeat (5) begin
            stimSeed = lcgNext(stimSeed);
            runOp(opPush, stimSeed);
        end
        writesBefore = writeCount;
        newPointer   = base - 32'd4;
        swap         = 1'b1;
        @(posedge clk);
        #1;
        swap = 1'b0;
        runOp(opPeek, '0);
        assert (writeCount == writesBefore + 1) else begin
            $display("Swap did not write the dirty line to memory exactly once");
            stopRun();
        end
        randomOps(40);
        if ((acceptCount > 0) && (faultCount > 0) && (writeCount > 0)) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Run ended without accepts, bound faults or line writes to check");
            stopRun();
        end
    end

endmodule

`default_nettype wire
